//--- common/fb_defines.svh
//////////////////////////////////////////////////////////////////////
// Sizes, word widths and command opcodes of the framebuffer back end.
// Include this file wherever one of the macros is needed.
//////////////////////////////////////////////////////////////////////
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// Screen of 16 x 16 pixels
`define FB_X_BITS       4
`define FB_Y_BITS       4
`define FB_PIXELS       256

`define FB_CMD_WIDTH    32
`define FB_COLOR_WIDTH  16
`define FB_DEPTH_WIDTH  16

// Opcodes sit in the top four bits of a command word
`define FB_OP_SCISSOR_START  4'h1
`define FB_OP_SCISSOR_END    4'h2
`define FB_OP_CLEAR_COLOR    4'h3
`define FB_OP_CLEAR_DEPTH    4'h4
`define FB_OP_MASK           4'h5
`define FB_OP_CLEAR          4'h6
`define FB_OP_COMMIT         4'h7

`endif

//--- common/fb_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types shared by the framebuffer back end: vector widths, the
// fragment and configuration structs, the FSM states and the
// RGB888 to RGB565 conversion.
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "fb_defines.svh"

package fb_pkg;

    typedef logic [`FB_X_BITS-1:0]                 screen_pos_t;
    typedef logic [`FB_X_BITS+`FB_Y_BITS-1:0]      pixel_index_t;
    typedef logic [`FB_CMD_WIDTH-1:0]              cmd_word_t;
    typedef logic [23:0]                           rgb888_t;
    typedef logic [`FB_COLOR_WIDTH-1:0]            rgb565_t;
    typedef logic [`FB_DEPTH_WIDTH-1:0]            depth_t;
    // Color in the upper half, depth in the lower half
    typedef logic [`FB_COLOR_WIDTH+`FB_DEPTH_WIDTH-1:0] fb_word_t;

    typedef struct packed {
        screen_pos_t x;
        screen_pos_t y;
        rgb888_t     color;
        depth_t      depth;
    } fragment_t;

    // Scissor bounds are inclusive
    typedef struct packed {
        screen_pos_t scissor_start_x;
        screen_pos_t scissor_start_y;
        screen_pos_t scissor_end_x;
        screen_pos_t scissor_end_y;
        rgb565_t     clear_color;
        depth_t      clear_depth;
        logic        color_en;
        logic        depth_en;
    } fb_conf_t;

    typedef enum logic {BUF_IDLE, BUF_CLEAR} buf_state_t;
    typedef enum logic {STR_IDLE, STR_RUN} stream_state_t;

    function automatic rgb565_t to_rgb565(input rgb888_t c);
        return {c[23:19], c[15:10], c[7:3]};
    endfunction

endpackage

`default_nettype wire

//--- src/cmd_decoder.sv
//////////////////////////////////////////////////////////////////////
// Command decoder. Holds the scissor, clear values and write enables,
// turns CLEAR and COMMIT into start pulses and reports when the
// back end is idle.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module cmd_decoder (
    input  logic              aclk,
    input  logic              rst,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  fb_pkg::cmd_word_t cmd_data,
    output fb_pkg::fb_conf_t  conf,
    output logic              clear_start,
    output logic              commit_start,
    input  logic              color_busy,
    input  logic              depth_busy,
    input  logic              stream_busy,
    output logic              backend_idle
);
    import fb_pkg::*;

    logic       cmd_hs;
    logic       start_hs;
    logic [3:0] opcode;
    logic       pending;

    assign opcode   = cmd_data[`FB_CMD_WIDTH-1 -: 4];
    assign cmd_hs   = cmd_valid && cmd_ready;
    assign start_hs = cmd_hs && ((opcode == `FB_OP_CLEAR) || (opcode == `FB_OP_COMMIT));

    // Start pulse is out but no busy has risen yet
    assign pending = clear_start || commit_start;

    assign cmd_ready    = !pending && !color_busy && !depth_busy && !stream_busy;
    // No fragment slips in beside a CLEAR or COMMIT
    assign backend_idle = cmd_ready && !start_hs;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            conf.scissor_start_x <= '0;
            conf.scissor_start_y <= '0;
            conf.scissor_end_x   <= '1;
            conf.scissor_end_y   <= '1;
            conf.clear_color     <= '0;
            conf.clear_depth     <= '0;
            conf.color_en        <= 1'b1;
            conf.depth_en        <= 1'b1;
            clear_start          <= 1'b0;
            commit_start         <= 1'b0;
        end
        else
        begin
            clear_start  <= cmd_hs && (opcode == `FB_OP_CLEAR);
            commit_start <= cmd_hs && (opcode == `FB_OP_COMMIT);
            if (cmd_hs)
            begin
                case (opcode)
                    `FB_OP_SCISSOR_START:
                    begin
                        conf.scissor_start_x <= cmd_data[3:0];
                        conf.scissor_start_y <= cmd_data[7:4];
                    end
                    `FB_OP_SCISSOR_END:
                    begin
                        conf.scissor_end_x <= cmd_data[3:0];
                        conf.scissor_end_y <= cmd_data[7:4];
                    end
                    `FB_OP_CLEAR_COLOR: conf.clear_color <= to_rgb565(cmd_data[23:0]);
                    `FB_OP_CLEAR_DEPTH: conf.clear_depth <= cmd_data[15:0];
                    `FB_OP_MASK:
                    begin
                        conf.color_en <= cmd_data[0];
                        conf.depth_en <= cmd_data[1];
                    end
                    // Unknown opcodes are dropped
                    default: ;
                endcase
            end
        end
    end

    a_single_start: assert property (@(posedge aclk) disable iff (rst)
        !(clear_start && commit_start));

endmodule

`default_nettype wire

//--- src/fragment_router.sv
//////////////////////////////////////////////////////////////////////
// Fragment router. Scissor test, raster index and RGB565 conversion
// for each accepted fragment, then one registered write per buffer
// gated by that buffer's enable.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fragment_router (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 frag_valid,
    output logic                 frag_ready,
    input  fb_pkg::fragment_t    frag,
    input  logic                 backend_idle,
    input  fb_pkg::fb_conf_t     conf,
    output logic                 color_wr_en,
    output fb_pkg::rgb565_t      color_wr_data,
    output logic                 depth_wr_en,
    output fb_pkg::depth_t       depth_wr_data,
    output fb_pkg::pixel_index_t wr_index
);
    import fb_pkg::*;

    logic         frag_hs;
    logic         in_scissor;
    pixel_index_t frag_index;

    assign frag_ready = backend_idle;
    assign frag_hs    = frag_valid && frag_ready;

    // Bounds are inclusive on both ends
    assign in_scissor = (frag.x >= conf.scissor_start_x) && (frag.x <= conf.scissor_end_x)
                     && (frag.y >= conf.scissor_start_y) && (frag.y <= conf.scissor_end_y);

    // y * 16 + x
    assign frag_index = {frag.y, frag.x};

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            color_wr_en <= 1'b0;
            depth_wr_en <= 1'b0;
        end
        else
        begin
            color_wr_en <= frag_hs && in_scissor && conf.color_en;
            depth_wr_en <= frag_hs && in_scissor && conf.depth_en;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (frag_hs)
        begin
            wr_index      <= frag_index;
            color_wr_data <= to_rgb565(frag.color);
            depth_wr_data <= frag.depth;
        end
    end

    a_write_follows_hs: assert property (@(posedge aclk) disable iff (rst)
        (color_wr_en || depth_wr_en) |-> $past(frag_hs));

endmodule

`default_nettype wire

//--- framebuffer/pixel_buffer.sv
//////////////////////////////////////////////////////////////////////
// On-chip pixel store with one write port and a synchronous read.
// A clear pass writes clear_value to every pixel, one per cycle;
// fragment writes share the port while no clear runs.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module pixel_buffer #(
    parameter int PIXEL_WIDTH = 16
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     clear_start,
    input  logic [PIXEL_WIDTH-1:0]   clear_value,
    input  logic                     wr_en,
    input  fb_pkg::pixel_index_t     wr_index,
    input  logic [PIXEL_WIDTH-1:0]   wr_data,
    input  fb_pkg::pixel_index_t     rd_index,
    output logic [PIXEL_WIDTH-1:0]   rd_data,
    output logic                     busy
);
    import fb_pkg::*;

    localparam pixel_index_t LAST_INDEX = pixel_index_t'(`FB_PIXELS - 1);

    logic [PIXEL_WIDTH-1:0] mem [0:`FB_PIXELS-1];

    buf_state_t             state;
    pixel_index_t           clear_index;

    logic                   port_en;
    pixel_index_t           port_index;
    logic [PIXEL_WIDTH-1:0] port_data;

    assign busy = (state == BUF_CLEAR);

    // Clear pass owns the port while it runs
    always_comb
    begin
        if (state == BUF_CLEAR)
        begin
            port_en    = 1'b1;
            port_index = clear_index;
            port_data  = clear_value;
        end
        else
        begin
            port_en    = wr_en;
            port_index = wr_index;
            port_data  = wr_data;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state       <= BUF_IDLE;
            clear_index <= '0;
        end
        else
        begin
            case (state)
                BUF_IDLE:
                begin
                    if (clear_start)
                    begin
                        state       <= BUF_CLEAR;
                        clear_index <= '0;
                    end
                end
                BUF_CLEAR:
                begin
                    clear_index <= clear_index + 1'b1;
                    if (clear_index == LAST_INDEX)
                        state <= BUF_IDLE;
                end
                default: state <= BUF_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (port_en)
            mem[port_index] <= port_data;
        rd_data <= mem[rd_index];
    end

    // Decoder holds back new starts until the pass is done
    a_no_restart: assert property (@(posedge aclk) disable iff (rst)
        clear_start |-> !busy);

    // Fragments in flight must land before the pass begins
    a_no_write_in_clear: assert property (@(posedge aclk) disable iff (rst)
        busy |-> !wr_en);

endmodule

`default_nettype wire

//--- framebuffer/frame_streamer.sv
//////////////////////////////////////////////////////////////////////
// Frame streamer. On commit it walks all pixels in raster order,
// reads color and depth together and sends one packed word per pixel
// with valid/ready flow control.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module frame_streamer (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 commit_start,
    output fb_pkg::pixel_index_t rd_index,
    input  fb_pkg::rgb565_t      color_rd_data,
    input  fb_pkg::depth_t       depth_rd_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fb_pkg::fb_word_t     out_data,
    output logic                 out_last,
    output logic                 busy
);
    import fb_pkg::*;

    localparam pixel_index_t LAST_INDEX = pixel_index_t'(`FB_PIXELS - 1);

    stream_state_t state;
    // Pixel whose data shows on the read ports when rd_valid is set
    pixel_index_t  data_index;
    logic          rd_valid;
    logic          take;

    assign take = (state == STR_RUN) && rd_valid && (!out_valid || out_ready);

    // Hold the address during a stall so the read data stays put
    assign rd_index = take ? pixel_index_t'(data_index + 1'b1) : data_index;

    assign busy = (state == STR_RUN) || out_valid;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state      <= STR_IDLE;
            data_index <= '0;
            rd_valid   <= 1'b0;
        end
        else
        begin
            case (state)
                STR_IDLE:
                begin
                    if (commit_start)
                    begin
                        state      <= STR_RUN;
                        data_index <= '0;
                        rd_valid   <= 1'b0;
                    end
                end
                STR_RUN:
                begin
                    rd_valid <= 1'b1;
                    if (take)
                    begin
                        data_index <= data_index + 1'b1;
                        if (data_index == LAST_INDEX)
                        begin
                            state    <= STR_IDLE;
                            rd_valid <= 1'b0;
                        end
                    end
                end
                default: state <= STR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
        else if (take)
        begin
            out_valid <= 1'b1;
            out_last  <= (data_index == LAST_INDEX);
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (take)
            out_data <= {color_rd_data, depth_rd_data};
    end

    a_stall_stable: assert property (@(posedge aclk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

//--- src/fb_backend.sv
//////////////////////////////////////////////////////////////////////
// Framebuffer back end top level. Commands and fragments come in,
// color and depth buffers sit side by side, and the streamer sends
// the combined frame out on commit.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module fb_backend (
    input  logic              aclk,
    input  logic              rst,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  fb_pkg::cmd_word_t cmd_data,
    input  logic              frag_valid,
    output logic              frag_ready,
    input  fb_pkg::fragment_t frag,
    output logic              out_valid,
    input  logic              out_ready,
    output fb_pkg::fb_word_t  out_data,
    output logic              out_last
);
    import fb_pkg::*;

    fb_conf_t     conf;
    logic         clear_start;
    logic         commit_start;
    logic         backend_idle;
    logic         color_busy;
    logic         depth_busy;
    logic         stream_busy;

    logic         color_wr_en;
    rgb565_t      color_wr_data;
    logic         depth_wr_en;
    depth_t       depth_wr_data;
    pixel_index_t wr_index;

    pixel_index_t rd_index;
    rgb565_t      color_rd_data;
    depth_t       depth_rd_data;

    cmd_decoder cmd_decoder_i (
        .aclk         (aclk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_data     (cmd_data),
        .conf         (conf),
        .clear_start  (clear_start),
        .commit_start (commit_start),
        .color_busy   (color_busy),
        .depth_busy   (depth_busy),
        .stream_busy  (stream_busy),
        .backend_idle (backend_idle)
    );

    fragment_router fragment_router_i (
        .aclk          (aclk),
        .rst           (rst),
        .frag_valid    (frag_valid),
        .frag_ready    (frag_ready),
        .frag          (frag),
        .backend_idle  (backend_idle),
        .conf          (conf),
        .color_wr_en   (color_wr_en),
        .color_wr_data (color_wr_data),
        .depth_wr_en   (depth_wr_en),
        .depth_wr_data (depth_wr_data),
        .wr_index      (wr_index)
    );

    pixel_buffer #(
        .PIXEL_WIDTH (`FB_COLOR_WIDTH)
    ) color_buffer (
        .aclk        (aclk),
        .rst         (rst),
        .clear_start (clear_start),
        .clear_value (conf.clear_color),
        .wr_en       (color_wr_en),
        .wr_index    (wr_index),
        .wr_data     (color_wr_data),
        .rd_index    (rd_index),
        .rd_data     (color_rd_data),
        .busy        (color_busy)
    );

    pixel_buffer #(
        .PIXEL_WIDTH (`FB_DEPTH_WIDTH)
    ) depth_buffer (
        .aclk        (aclk),
        .rst         (rst),
        .clear_start (clear_start),
        .clear_value (conf.clear_depth),
        .wr_en       (depth_wr_en),
        .wr_index    (wr_index),
        .wr_data     (depth_wr_data),
        .rd_index    (rd_index),
        .rd_data     (depth_rd_data),
        .busy        (depth_busy)
    );

    frame_streamer frame_streamer_i (
        .aclk          (aclk),
        .rst           (rst),
        .commit_start  (commit_start),
        .rd_index      (rd_index),
        .color_rd_data (color_rd_data),
        .depth_rd_data (depth_rd_data),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_last      (out_last),
        .busy          (stream_busy)
    );

endmodule

`default_nettype wire

//--- tests/tb_fb_backend.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the framebuffer back end. Drives commands, fragments
// and out_ready, keeps a model of every pixel and checks the output
// stream with concurrent assertions against that model.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module tb_fb_backend;
    import fb_pkg::*;

    // About 5000 cycles of traffic, so four times that is plenty
    localparam int WATCHDOG_NS = 2_000_000;

    logic         aclk;
    logic         rst;
    logic         cmd_valid;
    logic         cmd_ready;
    cmd_word_t    cmd_data;
    logic         frag_valid;
    logic         frag_ready;
    fragment_t    frag_in;
    logic         out_valid;
    logic         out_ready;
    fb_word_t     out_data;
    logic         out_last;

    fb_word_t     exp_mem [0:`FB_PIXELS-1];
    screen_pos_t  m_sx;
    screen_pos_t  m_sy;
    screen_pos_t  m_ex;
    screen_pos_t  m_ey;
    rgb565_t      m_clear_color;
    depth_t       m_clear_depth;
    logic         m_color_en;
    logic         m_depth_en;

    pixel_index_t out_idx;
    int           commits_done;
    logic         start_offered;
    logic         in_op;
    int           blocked;
    logic         random_ready;
    integer       seed = 32'hf5a208d3;

    fb_backend fb_backend_i (
        .aclk       (aclk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_data   (cmd_data),
        .frag_valid (frag_valid),
        .frag_ready (frag_ready),
        .frag       (frag_in),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last)
    );

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish in time");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    task automatic fail_check(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Keep the top bits of each 8-bit channel
    function automatic rgb565_t rgb888_to_565(input rgb888_t c);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = c[23:16] >> 3;
        g = c[15:8] >> 2;
        b = c[7:0] >> 3;
        return {r[4:0], g[5:0], b[4:0]};
    endfunction

    // Ready pattern: 3 of 4 cycles on average when randomized
    initial
    begin
        logic [31:0] r;
        out_ready = 1'b1;
        forever
        begin
            @(negedge aclk);
            r = $random(seed);
            out_ready = random_ready ? (r[1:0] != 2'b00) : 1'b1;
        end
    end

    always @(posedge aclk)
    begin
        if (rst)
        begin
            out_idx      <= '0;
            commits_done <= 0;
        end
        else if (out_valid && out_ready)
        begin
            out_idx <= out_last ? '0 : pixel_index_t'(out_idx + 1'b1);
            if (out_last)
                commits_done <= commits_done + 1;
        end
    end

    assign start_offered = cmd_valid && (cmd_data[31:28] == `FB_OP_CLEAR
                                         || cmd_data[31:28] == `FB_OP_COMMIT);

    // Counts cycles with cmd_ready low after a CLEAR or COMMIT
    always @(posedge aclk)
    begin
        if (rst)
        begin
            in_op   <= 1'b0;
            blocked <= 0;
        end
        else if (start_offered && cmd_ready)
        begin
            in_op   <= 1'b1;
            blocked <= 0;
        end
        else if (in_op)
        begin
            if (cmd_ready)
                in_op <= 1'b0;
            else
                blocked <= blocked + 1;
        end
    end

    a_word: assert property (@(posedge aclk) disable iff (rst)
        (out_valid && out_ready) |-> (out_data == exp_mem[out_idx]))
    else fail_check($sformatf("mismatch at %0t: pixel %0d got %h expected %h",
                              $time, out_idx, out_data, exp_mem[out_idx]));

    a_last: assert property (@(posedge aclk) disable iff (rst)
        out_valid |-> (out_last == (out_idx == 8'd255)))
    else fail_check($sformatf("mismatch at %0t: out_last wrong on pixel %0d",
                              $time, out_idx));

    a_hold: assert property (@(posedge aclk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
    else fail_check("output word changed or vanished while stalled");

    // Idle drops already in the cycle that takes a CLEAR or COMMIT
    a_ready_pair: assert property (@(posedge aclk) disable iff (rst)
        frag_ready == (cmd_ready && !start_offered))
    else fail_check("frag_ready does not follow the idle level of the back end");

    a_busy_output: assert property (@(posedge aclk) disable iff (rst)
        out_valid |-> !cmd_ready)
    else fail_check("cmd_ready was high while the frame was streaming");

    a_blocked: assert property (@(posedge aclk) disable iff (rst)
        (in_op && cmd_ready) |-> (blocked >= 256))
    else fail_check("ready came back before the clear or commit had finished");

    task automatic send_cmd(input logic [3:0] op, input logic [27:0] arg);
        @(negedge aclk);
        cmd_valid = 1'b1;
        cmd_data  = {op, arg};
        while (!cmd_ready)
            @(negedge aclk);
        @(posedge aclk);
        case (op)
            `FB_OP_SCISSOR_START:
            begin
                m_sx = arg[3:0];
                m_sy = arg[7:4];
            end
            `FB_OP_SCISSOR_END:
            begin
                m_ex = arg[3:0];
                m_ey = arg[7:4];
            end
            `FB_OP_CLEAR_COLOR: m_clear_color = rgb888_to_565(arg[23:0]);
            `FB_OP_CLEAR_DEPTH: m_clear_depth = arg[15:0];
            `FB_OP_MASK:
            begin
                m_color_en = arg[0];
                m_depth_en = arg[1];
            end
            `FB_OP_CLEAR:
            begin
                for (int i = 0; i < `FB_PIXELS; i++)
                    exp_mem[i[7:0]] = {m_clear_color, m_clear_depth};
            end
            default: ;
        endcase
        @(negedge aclk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_frag(input screen_pos_t x, input screen_pos_t y,
                             input rgb888_t color, input depth_t depth);
        pixel_index_t idx;
        @(negedge aclk);
        frag_valid    = 1'b1;
        frag_in.x     = x;
        frag_in.y     = y;
        frag_in.color = color;
        frag_in.depth = depth;
        while (!frag_ready)
            @(negedge aclk);
        @(posedge aclk);
        idx = pixel_index_t'(y * 16 + x);
        if (x >= m_sx && x <= m_ex && y >= m_sy && y <= m_ey)
        begin
            if (m_color_en)
                exp_mem[idx][31:16] = rgb888_to_565(color);
            if (m_depth_en)
                exp_mem[idx][15:0] = depth;
        end
        @(negedge aclk);
        frag_valid = 1'b0;
    endtask

    task automatic send_random_frags(input int count);
        logic [31:0] r1;
        logic [31:0] r2;
        for (int n = 0; n < count; n++)
        begin
            r1 = $random(seed);
            r2 = $random(seed);
            send_frag(r1[3:0], r1[7:4], r2[23:0], r1[31:16]);
        end
    endtask

    task automatic run_commit();
        int prev;
        prev = commits_done;
        send_cmd(`FB_OP_COMMIT, 28'h0);
        wait (commits_done == prev + 1);
        @(negedge aclk);
    endtask

    initial
    begin
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_data     = '0;
        frag_valid   = 1'b0;
        frag_in      = '0;
        random_ready = 1'b0;
        m_sx = 4'h0;
        m_sy = 4'h0;
        m_ex = 4'hf;
        m_ey = 4'hf;
        m_clear_color = '0;
        m_clear_depth = '0;
        m_color_en = 1'b1;
        m_depth_en = 1'b1;
        for (int i = 0; i < `FB_PIXELS; i++)
            exp_mem[i[7:0]] = '0;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;

        @(negedge aclk);
        a_after_reset: assert (cmd_ready && frag_ready && !out_valid && !out_last)
        else fail_check("handshake outputs are wrong after reset");
        run_commit();

        send_cmd(`FB_OP_CLEAR_COLOR, 28'h0c4a7e1);
        send_cmd(`FB_OP_CLEAR_DEPTH, 28'h000beef);
        send_cmd(`FB_OP_CLEAR, 28'h0);
        run_commit();

        send_cmd(`FB_OP_SCISSOR_START, 28'h34);
        send_cmd(`FB_OP_SCISSOR_END, 28'hcb);
        send_random_frags(40);
        run_commit();
        send_cmd(`FB_OP_SCISSOR_START, 28'h00);
        send_cmd(`FB_OP_SCISSOR_END, 28'hff);

        send_cmd(`FB_OP_MASK, 28'h2);
        send_random_frags(20);
        run_commit();
        send_cmd(`FB_OP_MASK, 28'h1);
        send_random_frags(20);
        run_commit();
        send_cmd(`FB_OP_MASK, 28'h3);

        random_ready = 1'b1;
        run_commit();
        send_random_frags(10);
        run_commit();
        random_ready = 1'b0;

        // Offered while the clear runs, then while the commit runs
        send_cmd(`FB_OP_CLEAR_COLOR, 28'h05193f7);
        send_cmd(`FB_OP_CLEAR, 28'h0);
        send_frag(4'h7, 4'h9, 24'h8844cc, 16'h1234);
        send_cmd(`FB_OP_COMMIT, 28'h0);
        send_cmd(`FB_OP_MASK, 28'h1);
        send_random_frags(10);
        run_commit();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/fb_pkg.sv
src/cmd_decoder.sv
src/fragment_router.sv
framebuffer/pixel_buffer.sv
framebuffer/frame_streamer.sv
src/fb_backend.sv
tests/tb_fb_backend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the framebuffer back end testbench with Verilator.
# Run from the project root.

LOG=sim.log
TOP=tb_fb_backend

verilator --binary --timing --assert -f sources.f --top-module "$TOP" --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
